// File: all.f
+incdir+include
hw/ndn_pkt_pkg.sv
hw/ndn_tbl_pkg.sv
hw/ndn_rx_parser.sv
hw/fib_table.sv
hw/pit_table.sv
hw/ndn_tx_serializer.sv
hw/ndn_forwarder_top.sv
dv/ndn_forwarder_assertions.sv
dv/ndn_forwarder_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= ndn_forwarder_tb
FLIST     ?= all.f

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

// File: dv/ndn_forwarder_tb.sv
`timescale 1ns/10ps
`include "ndn_defines.svh"

module ndn_forwarder_tb;

    localparam int TIMEOUT = 3000;
    localparam int FIB_N   = `NDN_FIB_DEPTH;
    localparam int PIT_N   = `NDN_PIT_DEPTH;

    logic        clk;
    logic        rst_n;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic [1:0]  rx_face;
    logic        rx_busy;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic        tx_last;
    logic [3:0]  tx_face_mask;
    logic        tx_ready;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;

    // Reference tables
    logic        m_fib_valid  [FIB_N];
    logic [63:0] m_fib_prefix [FIB_N];
    logic [3:0]  m_fib_len    [FIB_N];
    logic [1:0]  m_fib_face   [FIB_N];
    logic        m_pit_valid  [PIT_N];
    logic [63:0] m_pit_prefix [PIT_N];
    logic [3:0]  m_pit_mask   [PIT_N];

    // Expected output bytes in order
    logic [7:0]  exp_data [$];
    logic        exp_last [$];
    logic [3:0]  exp_mask [$];

    int          err_cnt;
    int          pass_cnt;
    int          test_err;
    logic        rand_ready;
    logic        ready_next = 1'b1;
    logic [63:0] base;
    logic [63:0] pfx_keep [9];

    ndn_forwarder_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_face(rx_face), .rx_busy(rx_busy),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last),
        .tx_face_mask(tx_face_mask), .tx_ready(tx_ready),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
    );

    bind ndn_forwarder_top ndn_forwarder_assertions i_asrt (
        .clk(clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_busy(rx_busy),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_last(tx_last),
        .tx_face_mask(tx_face_mask), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, act, exp);
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic abort_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        n = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdat;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < TIMEOUT);
        if (!wb_ack) begin
            abort_timeout("Wishbone ack");
        end else begin
            rdat = wb_dat_o;
            // Master sees the ack on the next edge
            @(negedge clk);
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic fib_write(input int idx, input logic [63:0] pfx, input logic vld,
                             input logic [3:0] len, input logic [1:0] face);
        logic [31:0] dummy;
        wb_access(1'b1, 5'(idx * 4), pfx[63:32], dummy);
        wb_access(1'b1, 5'(idx * 4 + 1), pfx[31:0], dummy);
        wb_access(1'b1, 5'(idx * 4 + 2), {vld, 23'd0, len, 2'd0, face}, dummy);
        // Reserved word must ignore writes
        wb_access(1'b1, 5'(idx * 4 + 3), $urandom | 32'd1, dummy);
        m_fib_valid[idx]  = vld;
        m_fib_prefix[idx] = pfx;
        m_fib_len[idx]    = len;
        m_fib_face[idx]   = face;
    endtask

    task automatic push_out(input logic [7:0] b, input logic last, input logic [3:0] m);
        exp_data.push_back(b);
        exp_last.push_back(last);
        exp_mask.push_back(m);
    endtask

    task automatic push_pkt(input logic [7:0] meta, input logic [63:0] pfx,
                            input logic [31:0] pay, input logic is_data, input logic [3:0] m);
        push_out(meta, 1'b0, m);
        for (int i = 7; i >= 0; i--) begin
            push_out(pfx[i*8 +: 8], !is_data && i == 0, m);
        end
        if (is_data) begin
            for (int i = 3; i >= 0; i--) begin
                push_out(pay[i*8 +: 8], i == 0, m);
            end
        end
    endtask

    // Forwarding rules applied to the reference tables
    task automatic model_pkt(input logic is_data, input logic [6:0] low7,
                             input logic [63:0] pfx, input logic [31:0] pay,
                             input logic [1:0] face);
        int match;
        int free;
        int best_len;
        logic [1:0] best_face;
        logic [63:0] keep;
        match    = -1;
        free     = -1;
        best_len = 0;
        best_face = 0;
        for (int i = PIT_N - 1; i >= 0; i--) begin
            if (m_pit_valid[i] && m_pit_prefix[i] == pfx) match = i;
            if (!m_pit_valid[i]) free = i;
        end
        if (is_data) begin
            if (match >= 0) begin
                push_pkt({1'b1, low7}, pfx, pay, 1'b1, m_pit_mask[match]);
                m_pit_valid[match] = 1'b0;
            end
        end else if (low7 != 0) begin
            for (int i = 0; i < FIB_N; i++) begin
                keep = ~64'd0 << (8 * (8 - int'(m_fib_len[i])));
                if (m_fib_valid[i] && m_fib_len[i] >= 1 && m_fib_len[i] <= 8 &&
                    ((m_fib_prefix[i] ^ pfx) & keep) == 0 && m_fib_len[i] > best_len) begin
                    best_len  = m_fib_len[i];
                    best_face = m_fib_face[i];
                end
            end
            if (best_len > 0 && match >= 0) begin
                m_pit_mask[match] = m_pit_mask[match] | (4'd1 << face);
            end else if (best_len > 0 && free >= 0) begin
                m_pit_valid[free]  = 1'b1;
                m_pit_prefix[free] = pfx;
                m_pit_mask[free]   = 4'd1 << face;
                push_pkt({1'b0, low7 - 7'd1}, pfx, pay, 1'b0, 4'd1 << best_face);
            end
        end
    endtask

    task automatic send_pkt(input logic is_data, input logic [6:0] low7,
                            input logic [63:0] pfx, input logic [31:0] pay,
                            input logic [1:0] face);
        logic [7:0] b [13];
        int nb;
        int n;
        model_pkt(is_data, low7, pfx, pay, face);
        b[0] = {is_data, low7};
        for (int i = 0; i < 8; i++) b[1 + i] = pfx[(7 - i)*8 +: 8];
        for (int i = 0; i < 4; i++) b[9 + i] = pay[(3 - i)*8 +: 8];
        nb = is_data ? 13 : 9;
        n  = 0;
        @(negedge clk);
        while (rx_busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rx_busy) begin
            abort_timeout("rx_busy to fall");
        end else begin
            for (int i = 0; i < nb; i++) begin
                rx_valid = 1'b1;
                rx_data  = b[i];
                rx_face  = face;
                @(negedge clk);
            end
            rx_valid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while ((exp_data.size() != 0 || tx_valid || rx_busy) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_data.size() != 0 || tx_valid || rx_busy) abort_timeout("output to drain");
    endtask

    task automatic flush_pit();
        for (int i = 0; i < PIT_N; i++) begin
            if (m_pit_valid[i]) send_pkt(1'b1, 7'($urandom), m_pit_prefix[i], $urandom, 2'd3);
        end
        wait_idle();
    endtask

    task automatic end_test(input string name);
        wait_idle();
        $display("%s: %s (%0d errors)", name, err_cnt == test_err ? "ok" : "failed",
                 err_cnt - test_err);
        test_err = err_cnt;
    endtask

    // Output monitor against the expected byte queue
    always @(posedge clk) begin
        if (rst_n && tx_valid && tx_ready) begin
            if (exp_data.size() == 0) begin
                err_cnt++;
                $display("Unexpected output byte 0x%0h with nothing pending", tx_data);
            end else begin
                check("tx_data", tx_data, exp_data.pop_front());
                check("tx_last", tx_last, exp_last.pop_front());
                check("tx_face_mask", tx_face_mask, exp_mask.pop_front());
            end
        end
    end

    // Next tx_ready drawn on the rising edge, applied on the falling edge
    always @(posedge clk) begin
        ready_next = rand_ready ? 1'($urandom) : 1'b1;
    end

    always @(negedge clk) begin
        tx_ready = ready_next;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] exp_w;
        logic [63:0] pfx;
        logic [63:0] keep;
        int k;
        void'($urandom(32'h2983362e));
        err_cnt    = 0;
        pass_cnt   = 0;
        test_err   = 0;
        rand_ready = 1'b0;
        rst_n      = 1'b0;
        rx_valid   = 1'b0;
        rx_data    = '0;
        rx_face    = '0;
        tx_ready   = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_i   = '0;
        for (int i = 0; i < PIT_N; i++) m_pit_valid[i] = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // FIB register access
        for (int i = 0; i < FIB_N; i++) begin
            fib_write(i, {$urandom, $urandom}, 1'($urandom), 4'(1 + $urandom % 8), 2'($urandom));
        end
        for (int a = 0; a < FIB_N * 4; a++) begin
            wb_access(1'b0, 5'(a), 32'd0, rd);
            case (a % 4)
                0: exp_w = m_fib_prefix[a/4][63:32];
                1: exp_w = m_fib_prefix[a/4][31:0];
                2: exp_w = {m_fib_valid[a/4], 23'd0, m_fib_len[a/4], 2'd0, m_fib_face[a/4]};
                default: exp_w = 32'd0;
            endcase
            check("wb_dat_o", rd, exp_w);
        end
        end_test("fib register access");

        // Interest forwarding against mixed-length prefixes
        // Entry 6 is a full-length match of base but invalid
        base = {$urandom, $urandom};
        for (int i = 0; i < FIB_N; i++) begin
            fib_write(i, (i < 5 || i == 6) ? base : {$urandom, $urandom}, i != 6,
                      i == 0 ? 4'd1 : (i == 6 ? 4'd8 : 4'(1 + $urandom % 8)), 2'($urandom));
        end
        for (int t = 0; t < 30; t++) begin
            k    = $urandom % 9;
            keep = ~64'd0 << (8 * (8 - k));
            pfx  = (base & keep) | ({$urandom, $urandom} & ~keep);
            send_pkt(1'b0, ($urandom % 4 == 0) ? 7'd0 : 7'(1 + $urandom % 127), pfx, $urandom,
                     2'($urandom));
        end
        end_test("interest forwarding");
        flush_pit();

        // Aggregation of a repeated interest
        pfx = {base[63:32], $urandom};
        send_pkt(1'b0, 7'd20, pfx, 32'd0, 2'd0);
        send_pkt(1'b0, 7'd20, pfx, 32'd0, 2'd2);
        send_pkt(1'b1, 7'($urandom), pfx, $urandom, 2'd1);
        send_pkt(1'b1, 7'($urandom), pfx, $urandom, 2'd1);
        end_test("aggregation");

        // PIT capacity
        for (int i = 0; i < 9; i++) begin
            pfx_keep[i] = {base[63:56], 24'($urandom), $urandom};
            send_pkt(1'b0, 7'd5, pfx_keep[i], 32'd0, 2'($urandom));
        end
        send_pkt(1'b1, 7'd1, pfx_keep[0], $urandom, 2'd0);
        send_pkt(1'b0, 7'd5, pfx_keep[8], 32'd0, 2'd1);
        end_test("pit capacity");
        flush_pit();

        // Random traffic under back-pressure
        rand_ready = 1'b1;
        for (int t = 0; t < 40; t++) begin
            pfx = {base[63:8], 8'($urandom % 12)};
            send_pkt(($urandom % 3) == 0, 7'(1 + $urandom % 127), pfx, $urandom, 2'($urandom));
        end
        flush_pit();
        end_test("back-pressure");

        $display("checks passed %0d, errors %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: dv/ndn_forwarder_assertions.sv
`timescale 1ns/10ps

module ndn_forwarder_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       rx_valid,
    input logic       rx_busy,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic [7:0] tx_data,
    input logic       tx_last,
    input logic [3:0] tx_face_mask,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack
);

    // Output holds under back-pressure
    tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=>
            tx_valid && $stable(tx_data) && $stable(tx_last) && $stable(tx_face_mask))
        else $error("tx output changed while stalled");

    wb_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack outside a bus cycle");

    // A new packet starts on a rising rx_valid
    rx_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid && !$past(rx_valid) |-> !rx_busy)
        else $error("rx packet started while busy");

    tx_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid |-> tx_face_mask != '0)
        else $error("tx face mask empty");

endmodule

// File: hw/ndn_forwarder_top.sv
`timescale 1ns/10ps
`include "ndn_defines.svh"

module ndn_forwarder_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rx_valid,
    input  logic [7:0]              rx_data,
    input  ndn_pkt_pkg::face_id_t   rx_face,
    output logic                    rx_busy,
    output logic                    tx_valid,
    output logic [7:0]              tx_data,
    output logic                    tx_last,
    output ndn_pkt_pkg::face_mask_t tx_face_mask,
    input  logic                    tx_ready,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`NDN_WB_AW-1:0]   wb_adr,
    input  logic [`NDN_WB_DW-1:0]   wb_dat_i,
    output logic [`NDN_WB_DW-1:0]   wb_dat_o,
    output logic                    wb_ack
);

    logic                    pkt_valid;
    ndn_pkt_pkg::ndn_pkt_t   pkt;
    logic                    fib_valid;
    logic                    fib_hit;
    ndn_pkt_pkg::face_id_t   fib_face;
    logic                    tx_req;
    logic                    tx_ack;
    ndn_pkt_pkg::ndn_pkt_t   tx_pkt;
    ndn_pkt_pkg::face_mask_t pit_face_mask;
    logic                    pkt_done;

    ndn_rx_parser i_parser (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_face  (rx_face),
        .pkt_done (pkt_done),
        .rx_busy  (rx_busy),
        .pkt_valid(pkt_valid),
        .pkt      (pkt)
    );

    fib_table i_fib (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .pkt_valid(pkt_valid),
        .pkt      (pkt),
        .fib_valid(fib_valid),
        .fib_hit  (fib_hit),
        .fib_face (fib_face)
    );

    pit_table i_pit (
        .clk         (clk),
        .rst_n       (rst_n),
        .pkt_valid   (pkt_valid),
        .pkt         (pkt),
        .fib_valid   (fib_valid),
        .fib_hit     (fib_hit),
        .fib_face    (fib_face),
        .tx_ack      (tx_ack),
        .tx_req      (tx_req),
        .tx_pkt      (tx_pkt),
        .tx_face_mask(pit_face_mask),
        .pkt_done    (pkt_done)
    );

    ndn_tx_serializer i_ser (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_req      (tx_req),
        .tx_pkt      (tx_pkt),
        .tx_req_mask (pit_face_mask),
        .tx_ready    (tx_ready),
        .tx_ack      (tx_ack),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_last     (tx_last),
        .tx_face_mask(tx_face_mask)
    );

endmodule

// File: hw/ndn_tx_serializer.sv
`timescale 1ns/10ps
`include "ndn_defines.svh"

module ndn_tx_serializer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tx_req,
    input  ndn_pkt_pkg::ndn_pkt_t   tx_pkt,
    input  ndn_pkt_pkg::face_mask_t tx_req_mask,
    input  logic                    tx_ready,
    output logic                    tx_ack,
    output logic                    tx_valid,
    output logic [7:0]              tx_data,
    output logic                    tx_last,
    output ndn_pkt_pkg::face_mask_t tx_face_mask
);

    localparam int CW = ndn_pkt_pkg::PKT_CNT_W;
    localparam int SW = ndn_pkt_pkg::PKT_DATA_BYTES * 8;
    localparam logic [CW-1:0] N_INT  = CW'(ndn_pkt_pkg::PKT_INT_BYTES);
    localparam logic [CW-1:0] N_DATA = CW'(ndn_pkt_pkg::PKT_DATA_BYTES);

    logic          busy;
    // Bytes still to send, current byte at the top of sbuf
    logic [CW-1:0] left;
    logic [SW-1:0] sbuf;
    logic          xfer;

    assign tx_ack   = tx_req && !busy;
    assign tx_valid = busy;
    assign tx_data  = sbuf[SW-1 -: 8];
    assign tx_last  = busy && (left == CW'(1));
    assign xfer     = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (tx_ack) begin
            busy <= 1'b1;
        end else if (xfer && tx_last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_ack) begin
            // Interests stop after the prefix, payload bytes are never shifted out
            sbuf         <= {tx_pkt.meta, tx_pkt.prefix, tx_pkt.payload};
            left         <= tx_pkt.meta.data.is_data ? N_DATA : N_INT;
            tx_face_mask <= tx_req_mask;
        end else if (xfer) begin
            sbuf <= sbuf << 8;
            left <= left - 1'b1;
        end
    end

endmodule

// File: hw/pit_table.sv
`timescale 1ns/10ps
`include "ndn_defines.svh"

module pit_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pkt_valid,
    input  ndn_pkt_pkg::ndn_pkt_t   pkt,
    input  logic                    fib_valid,
    input  logic                    fib_hit,
    input  ndn_pkt_pkg::face_id_t   fib_face,
    input  logic                    tx_ack,
    output logic                    tx_req,
    output ndn_pkt_pkg::ndn_pkt_t   tx_pkt,
    output ndn_pkt_pkg::face_mask_t tx_face_mask,
    output logic                    pkt_done
);

    localparam int DEPTH = `NDN_PIT_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    ndn_tbl_pkg::pit_entry_t pit [DEPTH];

    logic             match_hit, free_hit;
    logic [IDX_W-1:0] match_idx, free_idx;
    logic             match_q, free_q;
    logic [IDX_W-1:0] match_idx_q, free_idx_q;
    logic             fwd_int, fwd_data, aggr;
    logic             done_q;

    function automatic ndn_pkt_pkg::face_mask_t onehot(input ndn_pkt_pkg::face_id_t f);
        return ndn_pkt_pkg::face_mask_t'(1) << f;
    endfunction

    // Exact match and first free slot, lowest index first
    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        free_hit  = 1'b0;
        free_idx  = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (pit[i].valid && pit[i].prefix == pkt.prefix) begin
                match_hit = 1'b1;
                match_idx = IDX_W'(i);
            end
            if (!pit[i].valid) begin
                free_hit = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    // Search runs while the FIB looks up, table is stable until the decision
    always_ff @(posedge clk) begin
        if (pkt_valid) begin
            match_q     <= match_hit;
            match_idx_q <= match_idx;
            free_q      <= free_hit;
            free_idx_q  <= free_idx;
        end
    end

    always_comb begin
        fwd_int  = 1'b0;
        fwd_data = 1'b0;
        aggr     = 1'b0;
        if (fib_valid) begin
            if (pkt.meta.data.is_data) begin
                fwd_data = match_q;
            end else if (pkt.meta.intr.hop_limit != '0 && fib_hit) begin
                aggr    = match_q;
                fwd_int = !match_q && free_q;
            end
        end
    end

    // Drops and aggregation finish next cycle, forwards finish on the ack
    assign pkt_done = done_q || (tx_req && tx_ack);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_req <= 1'b0;
            done_q <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                pit[i].valid <= 1'b0;
            end
        end else begin
            done_q <= fib_valid && !fwd_int && !fwd_data;
            if (tx_ack) begin
                tx_req <= 1'b0;
            end
            if (fwd_int || fwd_data) begin
                tx_req <= 1'b1;
            end
            if (fwd_data) begin
                pit[match_idx_q].valid <= 1'b0;
            end
            if (fwd_int) begin
                pit[free_idx_q].valid  <= 1'b1;
                pit[free_idx_q].prefix <= pkt.prefix;
                pit[free_idx_q].mask   <= onehot(pkt.face);
            end
            if (aggr) begin
                pit[match_idx_q].mask <= pit[match_idx_q].mask | onehot(pkt.face);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_int || fwd_data) begin
            tx_pkt <= pkt;
            if (fwd_int) begin
                tx_pkt.meta.intr.hop_limit <= pkt.meta.intr.hop_limit - 7'd1;
            end
            tx_face_mask <= fwd_data ? pit[match_idx_q].mask : onehot(fib_face);
        end
    end

endmodule

// File: hw/fib_table.sv
`timescale 1ns/10ps
`include "ndn_defines.svh"

module fib_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`NDN_WB_AW-1:0] wb_adr,
    input  logic [`NDN_WB_DW-1:0] wb_dat_i,
    output logic [`NDN_WB_DW-1:0] wb_dat_o,
    output logic                  wb_ack,
    input  logic                  pkt_valid,
    input  ndn_pkt_pkg::ndn_pkt_t pkt,
    output logic                  fib_valid,
    output logic                  fib_hit,
    output ndn_pkt_pkg::face_id_t fib_face
);

    localparam int DEPTH  = `NDN_FIB_DEPTH;
    localparam int IDX_W  = $clog2(DEPTH);
    localparam int WORD_W = $clog2(ndn_tbl_pkg::FIB_WORDS_PER_ENTRY);
    localparam int LEN_W  = ndn_tbl_pkg::FIB_LEN_W;
    localparam int FACE_W = ndn_pkt_pkg::FACE_W;

    ndn_tbl_pkg::fib_entry_t fib [DEPTH];

    logic                   wb_req;
    logic [IDX_W-1:0]       wb_idx;
    ndn_tbl_pkg::fib_word_t wb_word;
    logic [`NDN_WB_DW-1:0]  rd_word;
    logic                   best_hit;
    ndn_tbl_pkg::fib_len_t  best_len;
    ndn_pkt_pkg::face_id_t  best_face;

    // Byte mask covering the first len bytes of the prefix
    function automatic logic [63:0] len_mask(input ndn_tbl_pkg::fib_len_t len);
        logic [63:0] m;
        m = '1;
        return m << (8 * (int'(ndn_tbl_pkg::FIB_MAX_LEN) - int'(len)));
    endfunction

    assign wb_req  = wb_cyc && wb_stb && !wb_ack;
    assign wb_word = wb_adr[WORD_W-1:0];
    assign wb_idx  = wb_adr[WORD_W +: IDX_W];

    always_comb begin
        rd_word = '0;
        case (wb_word)
            ndn_tbl_pkg::FIB_W_PREFIX_HI: rd_word = fib[wb_idx].prefix[63:32];
            ndn_tbl_pkg::FIB_W_PREFIX_LO: rd_word = fib[wb_idx].prefix[31:0];
            ndn_tbl_pkg::FIB_W_CTRL: begin
                rd_word[ndn_tbl_pkg::FIB_CTRL_VALID]             = fib[wb_idx].valid;
                rd_word[ndn_tbl_pkg::FIB_CTRL_LEN_LSB +: LEN_W]  = fib[wb_idx].len;
                rd_word[ndn_tbl_pkg::FIB_CTRL_FACE_LSB +: FACE_W] = fib[wb_idx].face;
            end
            // Reserved word
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_o <= rd_word;
        end
    end

    // Writes land on the same edge that raises the ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                fib[i].valid <= 1'b0;
            end
        end else if (wb_req && wb_we) begin
            case (wb_word)
                ndn_tbl_pkg::FIB_W_PREFIX_HI: fib[wb_idx].prefix[63:32] <= wb_dat_i;
                ndn_tbl_pkg::FIB_W_PREFIX_LO: fib[wb_idx].prefix[31:0]  <= wb_dat_i;
                ndn_tbl_pkg::FIB_W_CTRL: begin
                    fib[wb_idx].valid <= wb_dat_i[ndn_tbl_pkg::FIB_CTRL_VALID];
                    fib[wb_idx].len   <= wb_dat_i[ndn_tbl_pkg::FIB_CTRL_LEN_LSB +: LEN_W];
                    fib[wb_idx].face  <= wb_dat_i[ndn_tbl_pkg::FIB_CTRL_FACE_LSB +: FACE_W];
                end
                default: ;
            endcase
        end
    end

    // Longest prefix match, strict compare keeps the lowest index on ties
    always_comb begin
        best_hit  = 1'b0;
        best_len  = '0;
        best_face = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (fib[i].valid && fib[i].len != '0 &&
                fib[i].len <= ndn_tbl_pkg::FIB_MAX_LEN &&
                ((fib[i].prefix ^ pkt.prefix) & len_mask(fib[i].len)) == '0 &&
                fib[i].len > best_len) begin
                best_hit  = 1'b1;
                best_len  = fib[i].len;
                best_face = fib[i].face;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fib_valid <= 1'b0;
            fib_hit   <= 1'b0;
        end else begin
            fib_valid <= pkt_valid;
            // Data packets never look up the FIB
            fib_hit   <= pkt_valid && !pkt.meta.data.is_data && best_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_valid) begin
            fib_face <= best_face;
        end
    end

endmodule

// File: hw/ndn_rx_parser.sv
`timescale 1ns/10ps
`include "ndn_defines.svh"

module ndn_rx_parser (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx_valid,
    input  logic [7:0]            rx_data,
    input  ndn_pkt_pkg::face_id_t rx_face,
    input  logic                  pkt_done,
    output logic                  rx_busy,
    output logic                  pkt_valid,
    output ndn_pkt_pkg::ndn_pkt_t pkt
);

    localparam int CW = ndn_pkt_pkg::PKT_CNT_W;
    localparam int PW = `NDN_PAYLOAD_BYTES * 8;
    localparam logic [CW-1:0] LAST_INT  = CW'(ndn_pkt_pkg::PKT_INT_BYTES - 1);
    localparam logic [CW-1:0] LAST_DATA = CW'(ndn_pkt_pkg::PKT_DATA_BYTES - 1);
    localparam logic [CW-1:0] LAST_PFX  = CW'(8);

    // Index of the next expected byte
    logic [CW-1:0] cnt;
    logic          take;
    logic          last;

    // Byte 0 only while idle, later bytes while a packet is open
    assign take = rx_valid && (cnt != '0 || !rx_busy);

    // Length known from the type bit once byte 0 is stored
    assign last = (cnt != '0) &&
                  (cnt == (pkt.meta.data.is_data ? LAST_DATA : LAST_INT));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            rx_busy   <= 1'b0;
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= take && last;
            if (take) begin
                rx_busy <= 1'b1;
                cnt     <= last ? '0 : cnt + 1'b1;
            end else if (pkt_done) begin
                rx_busy <= 1'b0;
            end
        end
    end

    // Packet fields, held until the next packet starts
    always_ff @(posedge clk) begin
        if (take) begin
            if (cnt == '0) begin
                pkt.meta    <= rx_data;
                pkt.face    <= rx_face;
                pkt.payload <= '0;
            end else if (cnt <= LAST_PFX) begin
                // MSB first
                pkt.prefix <= {pkt.prefix[55:0], rx_data};
            end else begin
                pkt.payload <= {pkt.payload[PW-9:0], rx_data};
            end
        end
    end

endmodule

// File: hw/ndn_tbl_pkg.sv
`include "ndn_defines.svh"

package ndn_tbl_pkg;

    // Register map, entry index * 4 + word
    localparam int FIB_WORDS_PER_ENTRY = 4;

    typedef logic [$clog2(FIB_WORDS_PER_ENTRY)-1:0] fib_word_t;

    localparam fib_word_t FIB_W_PREFIX_HI = 0;
    localparam fib_word_t FIB_W_PREFIX_LO = 1;
    localparam fib_word_t FIB_W_CTRL      = 2;

    // Control word fields
    localparam int FIB_CTRL_VALID    = 31;
    localparam int FIB_CTRL_LEN_LSB  = 4;
    localparam int FIB_CTRL_FACE_LSB = 0;

    // Prefix length in bytes, 1 to 8
    localparam int FIB_LEN_W = 4;
    typedef logic [FIB_LEN_W-1:0] fib_len_t;
    localparam fib_len_t FIB_MAX_LEN = 8;

    typedef struct packed {
        logic                  valid;
        logic [63:0]           prefix;
        fib_len_t              len;
        ndn_pkt_pkg::face_id_t face;
    } fib_entry_t;

    typedef struct packed {
        logic                    valid;
        logic [63:0]             prefix;
        ndn_pkt_pkg::face_mask_t mask;
    } pit_entry_t;

endpackage

// File: hw/ndn_pkt_pkg.sv
`include "ndn_defines.svh"

package ndn_pkt_pkg;

    localparam int FACE_W = $clog2(`NDN_FACES);

    // Metadata byte plus 8 prefix bytes
    localparam int PKT_INT_BYTES  = 9;
    localparam int PKT_DATA_BYTES = PKT_INT_BYTES + `NDN_PAYLOAD_BYTES;
    localparam int PKT_CNT_W      = $clog2(PKT_DATA_BYTES + 1);

    typedef logic [FACE_W-1:0]     face_id_t;
    typedef logic [`NDN_FACES-1:0] face_mask_t;

    typedef struct packed {
        logic       is_data;
        logic [6:0] hop_limit;
    } ndn_meta_int_t;

    // Freshness passes through the node untouched
    typedef struct packed {
        logic       is_data;
        logic [6:0] freshness;
    } ndn_meta_data_t;

    // Bit 7 selects the view, 1 = data
    typedef union packed {
        ndn_meta_int_t  intr;
        ndn_meta_data_t data;
    } ndn_meta_u;

    typedef struct packed {
        ndn_meta_u                       meta;
        logic [63:0]                     prefix;
        logic [`NDN_PAYLOAD_BYTES*8-1:0] payload;
        face_id_t                        face;
    } ndn_pkt_t;

endpackage

// File: include/ndn_defines.svh
`ifndef NDN_DEFINES_SVH
`define NDN_DEFINES_SVH

// Table depths
`define NDN_FIB_DEPTH 8
`define NDN_PIT_DEPTH 8

// Data packet payload length in bytes
`define NDN_PAYLOAD_BYTES 4

// Number of faces, face ids are log2 of this
`define NDN_FACES 4

// Wishbone word address and data widths
// 8 FIB entries x 4 words needs 5 address bits
`define NDN_WB_AW 5
`define NDN_WB_DW 32

`endif
